// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f src.f --top-module tb_fetch_predict -o sim_bin
	out=$$(./obj_dir/sim_bin 2>&1); echo "$$out"; echo "$$out" | grep -q "Test OK"

clean:
	rm -rf obj_dir

// ==== bp_consts.svh ====
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// Branch target buffer geometry

// PC bits kept per BTB tag
`define TAG_SIZE 10

// Tag starts at this PC bit, tag = pc[PC_ALIAS+TAG_SIZE-1:PC_ALIAS]
`define PC_ALIAS 10

// Stored target bits, the BTB keeps pc[TARGET_SIZE+1:2]
`define TARGET_SIZE 12

`define BTB_ROWS 8	// Number of CAM entries

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== branch_decode.sv ====
`timescale 1ns/1ps

`include "bp_consts.svh"

module branch_decode
	import isa_pkg::*;
	import predict_pkg::*;
(
	input  inst_t        inst,
	output logic         is_branch,
	output logic         is_jal,
	output branch_cond_e cond,
	output addr_t        offset
);

	opcode_e kind;
	addr_t   b_imm;
	addr_t   j_imm;

	// Classify the major opcode
	always_comb begin
		case (inst[6:0])
			BRANCH:  kind = BRANCH;
			JAL:     kind = JAL;
			default: kind = OTHER;
		endcase
	end

	assign is_branch = (kind == BRANCH);
	assign is_jal    = (kind == JAL);

	assign cond = branch_cond_e'(inst[14:12]);	// funct3 maps straight onto the enum

	// B-type immediate, bit 0 always zero
	assign b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

	// J-type immediate
	assign j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	assign offset = is_jal ? j_imm : b_imm;	// Only meaningful for branch or jal

endmodule

// ==== branch_execute.sv ====
`timescale 1ns/1ps

`include "bp_consts.svh"

module branch_execute
	import isa_pkg::*;
	import predict_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  ex_valid,	// One cycle pulse
	input  addr_t ex_pc,
	input  addr_t ex_pred_target,
	input  inst_t ex_inst,
	input  word_t ex_rs1,
	input  word_t ex_rs2,
	input  logic  ex_pred_taken,
	output logic  res_valid,
	output logic  res_taken,
	output logic  res_pred_taken,
	output addr_t res_pc,
	output addr_t res_target,
	output addr_t res_pred_target
);

	logic         is_branch;
	logic         is_jal;
	branch_cond_e cond;
	addr_t        offset;
	logic         cond_true;
	logic         taken;

	branch_decode u_branch_decode (
		.inst      (ex_inst),
		.is_branch (is_branch),
		.is_jal    (is_jal),
		.cond      (cond),
		.offset    (offset)
	);

	// Condition on the operands
	always_comb begin
		case (cond)
			BEQ:     cond_true = (ex_rs1 == ex_rs2);
			BNE:     cond_true = (ex_rs1 != ex_rs2);
			BLT:     cond_true = ($signed(ex_rs1) < $signed(ex_rs2));
			BGE:     cond_true = ($signed(ex_rs1) >= $signed(ex_rs2));
			BLTU:    cond_true = (ex_rs1 < ex_rs2);
			BGEU:    cond_true = (ex_rs1 >= ex_rs2);
			default: cond_true = 1'b0;	// Reserved funct3
		endcase
	end

	assign taken = is_jal || (is_branch && cond_true);	// jal always taken

	always_ff @(posedge clock) begin
		if (reset) res_valid <= 1'b0;
		else       res_valid <= ex_valid && (is_branch || is_jal);	// Others ignored
	end

	// Outcome travels with the recorded prediction
	always_ff @(posedge clock) begin
		if (ex_valid) begin
			res_pc          <= ex_pc;
			res_taken       <= taken;
			res_target      <= taken ? ex_pc + offset : ex_pc + 32'd4;
			res_pred_taken  <= ex_pred_taken;
			res_pred_target <= ex_pred_target;
		end
	end

endmodule

// ==== branch_result.sv ====
`timescale 1ns/1ps

`include "bp_consts.svh"

module branch_result
	import predict_pkg::*;
(
	input  logic  res_valid,
	input  logic  res_taken,
	input  logic  res_pred_taken,
	input  addr_t res_pc,
	input  addr_t res_target,
	input  addr_t res_pred_target,
	output logic  redirect,
	output addr_t redirect_pc,
	output logic  upd_valid,
	output addr_t upd_pc,
	output addr_t upd_target
);

	logic dir_wrong;
	logic tgt_wrong;

	assign dir_wrong = (res_taken != res_pred_taken);
	// Both taken but the BTB had a stale target
	assign tgt_wrong = res_taken && res_pred_taken && (res_target != res_pred_target);

	assign redirect    = res_valid && (dir_wrong || tgt_wrong);
	assign redirect_pc = res_target;	// Actual next PC

	// Train on every taken branch, not-taken leaves the table alone
	assign upd_valid  = res_valid && res_taken;
	assign upd_pc     = res_pc;
	assign upd_target = res_target;

endmodule

// ==== btb.sv ====
`timescale 1ns/1ps

`include "bp_consts.svh"

module btb
	import predict_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  lookup_en,	// Fetch side, instruction predecodes as branch or jal
	input  addr_t lookup_pc,
	output logic  hit,
	output addr_t hit_target,
	input  logic  upd_valid,	// Execute side, taken branch resolved
	input  addr_t upd_pc,
	input  addr_t upd_target
);

	// Table state
	logic [`BTB_ROWS-1:0] valid;
	btb_tag_t             tags    [`BTB_ROWS];
	btb_target_t          targets [`BTB_ROWS];
	btb_count_t           count;	// Rows in use, allocated from row 0 upward

	btb_tag_t    look_tag;
	logic        look_hit;
	btb_idx_t    look_idx;
	btb_tag_t    upd_tag;
	btb_target_t upd_bits;
	logic        upd_hit;
	btb_idx_t    upd_idx;
	logic        full;

	assign look_tag = lookup_pc[`PC_ALIAS+`TAG_SIZE-1:`PC_ALIAS];
	assign upd_tag  = upd_pc[`PC_ALIAS+`TAG_SIZE-1:`PC_ALIAS];	// Tag of the branch itself
	assign upd_bits = upd_target[`TARGET_SIZE+1:2];
	assign full     = (count == btb_count_t'(`BTB_ROWS));

	// Fetch CAM, lowest matching row wins
	always_comb begin
		look_hit = 1'b0;
		look_idx = '0;
		for (int i = `BTB_ROWS-1; i >= 0; i--) begin
			if (valid[i] && tags[i] == look_tag) begin
				look_hit = 1'b1;
				look_idx = btb_idx_t'(i);
			end
		end
	end

	assign hit = lookup_en & look_hit;

	// Upper PC bits and byte offset kept from the lookup PC
	assign hit_target = hit ?
		{lookup_pc[31:`TARGET_SIZE+2], targets[look_idx], lookup_pc[1:0]} : lookup_pc;

	// Update CAM, same priority
	always_comb begin
		upd_hit = 1'b0;
		upd_idx = '0;
		for (int i = `BTB_ROWS-1; i >= 0; i--) begin
			if (valid[i] && tags[i] == upd_tag) begin
				upd_hit = 1'b1;
				upd_idx = btb_idx_t'(i);
			end
		end
	end

	// Valid bits and count
	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
			count <= '0;
		end else if (upd_valid && !upd_hit && !full) begin
			valid[btb_idx_t'(count)] <= 1'b1;	// Next free row
			count                    <= count + 1'b1;
		end
		// When full the count stays, every row remains valid after the shift
	end

	// Tags and partial targets
	always_ff @(posedge clock) begin
		if (upd_valid) begin
			if (upd_hit) begin
				targets[upd_idx] <= upd_bits;	// Known branch, refresh target only
			end else if (full) begin
				// Oldest entry at row 0 falls out
				for (int i = 0; i < `BTB_ROWS-1; i++) begin
					tags[i]    <= tags[i+1];
					targets[i] <= targets[i+1];
				end
				tags[`BTB_ROWS-1]    <= upd_tag;
				targets[`BTB_ROWS-1] <= upd_bits;
			end else begin
				tags[btb_idx_t'(count)]    <= upd_tag;
				targets[btb_idx_t'(count)] <= upd_bits;
			end
		end
	end

endmodule

// ==== fetch_predict_top.sv ====
`timescale 1ns/1ps

`include "bp_consts.svh"

module fetch_predict_top
	import isa_pkg::*;
	import predict_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	// Wishbone fetch master
	output logic  wb_cyc,
	output logic  wb_stb,
	output addr_t wb_adr,
	input  inst_t wb_dat,
	input  logic  wb_ack,
	// Instruction port
	output logic  inst_valid,
	input  logic  inst_ready,
	output inst_t inst,
	output addr_t inst_pc,
	output logic  inst_pred_taken,
	output addr_t inst_pred_target,
	// Execute port
	input  logic  ex_valid,
	input  addr_t ex_pc,
	input  inst_t ex_inst,
	input  word_t ex_rs1,
	input  word_t ex_rs2,
	input  logic  ex_pred_taken,
	input  addr_t ex_pred_target,
	// Mispredict
	output logic  redirect,
	output addr_t redirect_pc
);

	logic  lookup_en;
	addr_t lookup_pc;
	logic  hit;
	addr_t hit_target;
	logic  res_valid;
	logic  res_taken;
	logic  res_pred_taken;
	addr_t res_pc;
	addr_t res_target;
	addr_t res_pred_target;
	logic  upd_valid;
	addr_t upd_pc;
	addr_t upd_target;

	fetch_unit u_fetch_unit (
		.clock            (clock),
		.reset            (reset),
		.wb_cyc           (wb_cyc),
		.wb_stb           (wb_stb),
		.wb_adr           (wb_adr),
		.wb_dat           (wb_dat),
		.wb_ack           (wb_ack),
		.lookup_en        (lookup_en),
		.lookup_pc        (lookup_pc),
		.hit              (hit),
		.hit_target       (hit_target),
		.inst_valid       (inst_valid),
		.inst_ready       (inst_ready),
		.inst             (inst),
		.inst_pc          (inst_pc),
		.inst_pred_target (inst_pred_target),
		.inst_pred_taken  (inst_pred_taken),
		.redirect         (redirect),
		.redirect_pc      (redirect_pc)
	);

	btb u_btb (
		.clock      (clock),
		.reset      (reset),
		.lookup_en  (lookup_en),
		.lookup_pc  (lookup_pc),
		.hit        (hit),
		.hit_target (hit_target),
		.upd_valid  (upd_valid),
		.upd_pc     (upd_pc),
		.upd_target (upd_target)
	);

	branch_execute u_branch_execute (
		.clock           (clock),
		.reset           (reset),
		.ex_valid        (ex_valid),
		.ex_pc           (ex_pc),
		.ex_pred_target  (ex_pred_target),
		.ex_inst         (ex_inst),
		.ex_rs1          (ex_rs1),
		.ex_rs2          (ex_rs2),
		.ex_pred_taken   (ex_pred_taken),
		.res_valid       (res_valid),
		.res_taken       (res_taken),
		.res_pred_taken  (res_pred_taken),
		.res_pc          (res_pc),
		.res_target      (res_target),
		.res_pred_target (res_pred_target)
	);

	branch_result u_branch_result (
		.res_valid       (res_valid),
		.res_taken       (res_taken),
		.res_pred_taken  (res_pred_taken),
		.res_pc          (res_pc),
		.res_target      (res_target),
		.res_pred_target (res_pred_target),
		.redirect        (redirect),
		.redirect_pc     (redirect_pc),
		.upd_valid       (upd_valid),
		.upd_pc          (upd_pc),
		.upd_target      (upd_target)
	);

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/1ps

`include "bp_consts.svh"

module fetch_unit
	import isa_pkg::*;
	import predict_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	// Wishbone classic, read only
	output logic  wb_cyc,
	output logic  wb_stb,
	output addr_t wb_adr,
	input  inst_t wb_dat,
	input  logic  wb_ack,
	// BTB lookup
	output logic  lookup_en,
	output addr_t lookup_pc,
	input  logic  hit,
	input  addr_t hit_target,
	// Instruction output register
	output logic  inst_valid,
	input  logic  inst_ready,
	output inst_t inst,
	output addr_t inst_pc,
	output addr_t inst_pred_target,
	output logic  inst_pred_taken,
	// Mispredict from the result stage
	input  logic  redirect,
	input  addr_t redirect_pc
);

	fetch_state_e state;
	addr_t        pc;	// Next address to fetch
	logic         is_branch;
	logic         is_jal;
	logic         out_free;
	logic         launch;
	logic         take;
	addr_t        pred_target;

	// Predecode the word on the bus
	branch_decode u_branch_decode (
		.inst      (wb_dat),
		.is_branch (is_branch),
		.is_jal    (is_jal),
		.cond      (),
		.offset    ()
	);

	assign wb_cyc = (state != FETCH_IDLE);
	assign wb_stb = wb_cyc;	// Classic single reads, stb follows cyc

	// Search BTB only when the word is actually wanted
	assign lookup_en = (state == FETCH_REQ) && wb_ack && (is_branch || is_jal);
	assign lookup_pc = wb_adr;

	assign pred_target = hit ? hit_target : wb_adr + 32'd4;

	assign out_free = !inst_valid || inst_ready;	// Register empty by next edge
	assign launch   = (state == FETCH_IDLE) && !redirect && out_free;
	assign take     = (state == FETCH_REQ) && wb_ack;	// Data arriving for a live request

	// Control state
	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= FETCH_IDLE;
			pc         <= `RESET_PC;
			inst_valid <= 1'b0;
		end else begin
			if (inst_valid && inst_ready) inst_valid <= 1'b0;	// Transferred
			case (state)
				FETCH_IDLE: begin
					if (launch) state <= FETCH_REQ;
				end
				FETCH_REQ: begin
					if (wb_ack) begin
						state <= FETCH_IDLE;	// One idle cycle after every ack
						if (!redirect) begin
							inst_valid <= 1'b1;
							pc         <= pred_target;
						end
					end else if (redirect) begin
						state <= FETCH_DROP;
					end
				end
				FETCH_DROP: begin
					if (wb_ack) state <= FETCH_IDLE;	// Stale data thrown away
				end
				default: state <= FETCH_IDLE;
			endcase
			// Redirect wins over everything above
			if (redirect) begin
				inst_valid <= 1'b0;
				pc         <= redirect_pc;
			end
		end
	end

	// Bus address and output payload
	always_ff @(posedge clock) begin
		if (launch) wb_adr <= pc;	// Held for the whole bus cycle
		if (take) begin
			inst             <= wb_dat;
			inst_pc          <= wb_adr;
			inst_pred_taken  <= hit;
			inst_pred_target <= pred_target;
		end
	end

endmodule

// ==== isa_pkg.sv ====
package isa_pkg;

	// One RV32 instruction word
	typedef logic [31:0] inst_t;

	// Major opcodes the predecoder cares about
	typedef enum logic [6:0] {
		BRANCH = 7'b1100011,	// B-type conditional branch
		JAL    = 7'b1101111,	// J-type jump and link
		OTHER  = 7'b0000000	// Anything else, never predicted
	} opcode_e;

	// Branch conditions, funct3 encoding
	typedef enum logic [2:0] {
		BEQ  = 3'b000,
		BNE  = 3'b001,
		BLT  = 3'b100,	// Signed
		BGE  = 3'b101,	// Signed
		BLTU = 3'b110,	// Unsigned
		BGEU = 3'b111	// Unsigned
	} branch_cond_e;

endpackage

// ==== predict_pkg.sv ====
`include "bp_consts.svh"

package predict_pkg;

	typedef logic [31:0] addr_t;	// Byte address
	typedef logic [31:0] word_t;	// Register operand

	// BTB fields
	typedef logic [`TAG_SIZE-1:0]    btb_tag_t;	// pc tag slice
	typedef logic [`TARGET_SIZE-1:0] btb_target_t;	// Partial target, pc[TARGET_SIZE+1:2]

	// Row index, and count which must also reach BTB_ROWS
	typedef logic [$clog2(`BTB_ROWS)-1:0] btb_idx_t;
	typedef logic [$clog2(`BTB_ROWS+1)-1:0] btb_count_t;

	// Fetch master states
	typedef enum logic [1:0] {
		FETCH_IDLE,	// No bus cycle, decides on next request
		FETCH_REQ,	// Bus cycle open, data wanted
		FETCH_DROP	// Bus cycle open, data discarded after redirect
	} fetch_state_e;

endpackage

// ==== src.f ====
+incdir+.
isa_pkg.sv
predict_pkg.sv
branch_decode.sv
btb.sv
fetch_unit.sv
branch_execute.sv
branch_result.sv
fetch_predict_top.sv
tb_fetch_predict.sv

// ==== tb_fetch_predict.sv ====
`timescale 1ns/1ps

`include "bp_consts.svh"

module tb_fetch_predict
	import isa_pkg::*;
	import predict_pkg::*;
();

	localparam int NBR = `BTB_ROWS + 1;	// One more branch than rows forces an eviction

	logic  clock, reset;
	logic  wb_cyc, wb_stb, wb_ack;
	addr_t wb_adr;
	inst_t wb_dat;
	logic  inst_valid, inst_ready, inst_pred_taken;
	inst_t inst, ex_inst;
	addr_t inst_pc, inst_pred_target, ex_pc, ex_pred_target, redirect_pc;
	logic  ex_valid, ex_pred_taken, redirect;
	word_t ex_rs1, ex_rs2;

	integer seed;
	logic   rand_ready;	// Back-pressure on or off
	int     wait_left;
	logic   pending;	// Bus cycle seen but not yet acked

	// Branch table of the program
	addr_t    br_pc [NBR];
	logic [2:0] br_cond [NBR];
	logic     br_jal [NBR];

	// Reference BTB with rows below ref_count valid
	btb_tag_t    ref_tag [`BTB_ROWS];
	btb_target_t ref_tgt [`BTB_ROWS];
	int          ref_count;

	// Monitor state
	addr_t exp_pc, snap_target, watch_pc;
	logic  snap_taken, stale, watch_hit, watch_pred;
	logic  pend_due, pend_mis, pend_taken;
	addr_t pend_pc, pend_target;
	logic  prev_cyc, prev_ack, prev_valid, prev_ready, prev_redirect;
	addr_t prev_adr, prev_pc, prev_ptarget;
	inst_t prev_inst;
	logic  prev_ptaken;
	int    xfer_count;

	fetch_predict_top u_fetch_predict_top (.*);

	always #20 clock = ~clock;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else
			fail_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
	endtask

	// B-type with rs1 x1 and rs2 x2
	function automatic inst_t enc_b(input logic [2:0] c, input addr_t off);
		return {off[12], off[10:5], 5'd2, 5'd1, c, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic inst_t enc_j(input addr_t off);
		return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
	endfunction

	// Branches at table PCs and OP-IMM words elsewhere, built from the full address
	function automatic inst_t mem_word(input addr_t a);
		for (int k = 0; k < NBR; k++)
			if (a == br_pc[k]) return br_jal[k] ? enc_j(-32'sd16) : enc_b(br_cond[k], -32'sd16);
		return {a[24:0] ^ a[31:7], 7'b0010011};
	endfunction

	function automatic logic is_cti(input addr_t a);
		for (int k = 0; k < NBR; k++)
			if (a == br_pc[k]) return 1'b1;
		return 1'b0;
	endfunction

	function automatic int ref_row(input addr_t a);
		int row;
		row = -1;
		for (int i = `BTB_ROWS - 1; i >= 0; i--)	// Lowest row wins
			if (i < ref_count && ref_tag[i] == a[`PC_ALIAS+`TAG_SIZE-1:`PC_ALIAS]) row = i;
		return row;
	endfunction

	function automatic void predict_ref(input addr_t a, output logic t, output addr_t tgt);
		int row;
		row = ref_row(a);
		t   = is_cti(a) && row >= 0;
		tgt = t ? {a[31:`TARGET_SIZE+2], ref_tgt[row], a[1:0]} : a + 32'd4;
	endfunction

	function automatic void train_ref(input addr_t a, input addr_t tgt);
		int row;
		row = ref_row(a);
		if (row >= 0) begin
			ref_tgt[row] = tgt[`TARGET_SIZE+1:2];
		end else if (ref_count < `BTB_ROWS) begin
			ref_tag[ref_count] = a[`PC_ALIAS+`TAG_SIZE-1:`PC_ALIAS];
			ref_tgt[ref_count] = tgt[`TARGET_SIZE+1:2];
			ref_count++;
		end else begin
			for (int i = 0; i < `BTB_ROWS - 1; i++) begin	// Oldest falls out of row 0
				ref_tag[i] = ref_tag[i+1];
				ref_tgt[i] = ref_tgt[i+1];
			end
			ref_tag[`BTB_ROWS-1] = a[`PC_ALIAS+`TAG_SIZE-1:`PC_ALIAS];
			ref_tgt[`BTB_ROWS-1] = tgt[`TARGET_SIZE+1:2];
		end
	endfunction

	function automatic logic outcome(input logic jal, input logic [2:0] c, input word_t a, b);
		if (jal) return 1'b1;
		case (c)
			3'b000:  return a == b;
			3'b001:  return a != b;
			3'b100:  return $signed(a) < $signed(b);
			3'b101:  return $signed(a) >= $signed(b);
			3'b110:  return a < b;
			3'b111:  return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// Wishbone slave with 0 to 3 wait cycles and random inst_ready
	always @(posedge clock) begin
		#1;
		inst_ready = rand_ready ? ($unsigned($random(seed)) % 4) != 0 : 1'b1;
		if (reset) begin
			wb_ack  = 1'b0;
			pending = 1'b0;
		end else if (wb_ack) begin
			wb_ack = 1'b0;	// Single beat
		end else if (wb_cyc) begin
			if (!pending) begin
				wait_left = $unsigned($random(seed)) % 4;
				pending   = 1'b1;
			end
			if (wait_left == 0) begin
				wb_ack  = 1'b1;
				wb_dat  = mem_word(wb_adr);
				pending = 1'b0;
			end else begin
				wait_left--;
			end
		end
	end

	// Protocol and output checks at mid cycle
	always @(negedge clock) begin
		if (!reset) begin
			assert (!wb_stb || wb_cyc) else fail_run("wb_stb high without wb_cyc");
			if (prev_cyc && !prev_ack) begin
				assert (wb_cyc && wb_stb) else fail_run("bus cycle dropped before ack");
				check_eq("wb_adr hold", prev_adr, wb_adr);
			end
			if (prev_ack) assert (!wb_cyc) else fail_run("new request in the cycle after ack");
			if (prev_valid && !prev_ready && !prev_redirect) begin
				assert (inst_valid) else fail_run("instruction lost under back-pressure");
				check_eq("hold inst", prev_inst, inst);
				check_eq("hold inst_pc", prev_pc, inst_pc);
				check_eq("hold pred_taken", prev_ptaken, inst_pred_taken);
				check_eq("hold pred_target", prev_ptarget, inst_pred_target);
			end
			if (inst_valid && inst_ready) begin
				check_eq("fetch pc", exp_pc, inst_pc);
				check_eq("fetch word", mem_word(inst_pc), inst);
				check_eq("pred_taken", snap_taken, inst_pred_taken);
				check_eq("pred_target", snap_target, inst_pred_target);
				exp_pc = inst_pred_target;
				xfer_count++;
				if (inst_pc == watch_pc) begin
					watch_hit  = 1'b1;
					watch_pred = inst_pred_taken;
				end
			end
			// Prediction taken from the table as it is at lookup
			if (wb_cyc && wb_ack) begin
				if (!stale && !redirect) predict_ref(wb_adr, snap_taken, snap_target);
				stale = 1'b0;
			end else if (wb_cyc && redirect) begin
				stale = 1'b1;	// In-flight data will be thrown away
			end
			if (pend_due) begin
				check_eq("redirect", pend_mis, redirect);
				if (pend_mis) check_eq("redirect_pc", pend_target, redirect_pc);
				if (pend_taken) train_ref(pend_pc, pend_target);
				pend_due = 1'b0;
			end else begin
				assert (!redirect) else fail_run("redirect without a resolved branch");
			end
			if (redirect) exp_pc = redirect_pc;
			if (ex_valid) pend_due = 1'b1;
			prev_cyc      = wb_cyc;
			prev_ack      = wb_ack;
			prev_adr      = wb_adr;
			prev_valid    = inst_valid;
			prev_ready    = inst_ready;
			prev_redirect = redirect;
			prev_inst     = inst;
			prev_pc       = inst_pc;
			prev_ptaken   = inst_pred_taken;
			prev_ptarget  = inst_pred_target;
		end
	end

	// One execute pulse with its expected result armed for the monitor
	task automatic resolve(input addr_t pc, input logic jal, input logic [2:0] c,
			input addr_t off, input word_t a, b, input logic pt, input addr_t ptg);
		int n;
		@(posedge clock);
		#1;
		pend_pc     = pc;
		pend_taken  = outcome(jal, c, a, b);
		pend_target = pend_taken ? pc + off : pc + 32'd4;
		pend_mis    = (pend_taken != pt) || (pend_taken && pt && pend_target != ptg);
		ex_valid       = 1'b1;
		ex_pc          = pc;
		ex_inst        = jal ? enc_j(off) : enc_b(c, off);
		ex_rs1         = a;
		ex_rs2         = b;
		ex_pred_taken  = pt;
		ex_pred_target = ptg;
		@(posedge clock);
		#1;
		ex_valid = 1'b0;
		n = 0;
		while (pend_due && n < 10) begin
			@(posedge clock);
			n++;
		end
		if (pend_due) fail_run("branch result never checked");
	endtask

	// Not-taken BEQ recorded as taken redirects to x without training
	task automatic steer(input addr_t x);
		resolve(x - 32'd4, 1'b0, 3'b000, 32'd64, 32'd1, 32'd2, 1'b1, x + 32'd8);
	endtask

	task automatic resolve_branch(input int k, input logic force_taken);
		logic  pt;
		addr_t ptg;
		word_t a, b;
		int    tries;
		predict_ref(br_pc[k], pt, ptg);	// Prediction the pipeline recorded
		tries = 0;
		do begin
			a = $random(seed);
			b = ($random(seed) & 1) ? a : $random(seed);
			tries++;
		end while (force_taken && !outcome(br_jal[k], br_cond[k], a, b) && tries < 64);
		if (force_taken && !outcome(br_jal[k], br_cond[k], a, b))
			fail_run("no taken operands found");
		resolve(br_pc[k], br_jal[k], br_cond[k], -32'sd16, a, b, pt, ptg);
	endtask

	task automatic wait_fetch(input addr_t pc);
		int n;
		watch_pc  = pc;
		watch_hit = 1'b0;
		n = 0;
		while (!watch_hit && n < 600) begin
			@(posedge clock);
			n++;
		end
		if (!watch_hit) fail_run($sformatf("pc %h never fetched", pc));
	endtask

	initial begin
		int n;
		seed = 32'h1921_76b2;
		clock = 0;
		reset = 1;
		rand_ready = 0;
		wb_ack = 0;
		wb_dat = '0;
		inst_ready = 1;
		pending = 0;
		wait_left = 0;
		ex_valid = 0;
		ex_pc = '0;
		ex_inst = '0;
		ex_rs1 = '0;
		ex_rs2 = '0;
		ex_pred_taken = 0;
		ex_pred_target = '0;
		ref_count = 0;
		exp_pc = `RESET_PC;
		stale = 0;
		pend_due = 0;
		xfer_count = 0;
		snap_taken = 0;
		snap_target = '0;
		watch_pc = 32'hffff_ffff;
		watch_hit = 0;
		prev_cyc = 0;
		prev_ack = 0;
		prev_valid = 0;
		prev_ready = 0;
		prev_redirect = 0;
		for (int k = 0; k < NBR; k++) begin
			br_pc[k]   = 32'h400 * (k + 1) + 32'h20;	// Distinct tags
			br_jal[k]  = (k % 7) == 6;
			br_cond[k] = (k % 7) < 2 ? 3'(k % 7) : 3'((k % 7) + 2);
		end
		repeat (3) @(posedge clock);
		#1 reset = 0;
		@(posedge clock);
		@(negedge clock);
		assert (wb_cyc) else fail_run("no fetch in the first cycle after reset");
		check_eq("first wb_adr", `RESET_PC, wb_adr);
		n = 0;
		while (xfer_count < 20 && n < 400) begin	// Sequential run with empty BTB
			@(posedge clock);
			n++;
		end
		if (xfer_count < 20) fail_run("sequential fetch stalled");
		rand_ready = 1;
		for (int k = 0; k < NBR; k++) begin
			steer(br_pc[k] - 32'd8);
			wait_fetch(br_pc[k]);
			repeat (3) resolve_branch(k, 1'b0);
			resolve_branch(k, 1'b1);
			steer(br_pc[k] - 32'd8);	// Walk into the branch again after training
			wait_fetch(br_pc[k]);
			check_eq("trained pred", 1, watch_pred);
		end
		for (int k = 0; k < NBR; k++) begin	// Oldest entry is gone
			steer(br_pc[k] - 32'd8);
			wait_fetch(br_pc[k]);
			check_eq($sformatf("pred after eviction %0d", k), k != 0, watch_pred);
		end
		$display("Test OK");
		$finish;
	end

endmodule
